// ==== design/cluster_periph_pkg.sv ====
// Peripheral package with address map, event and bus structs, and shared widths
`default_nettype none

package cluster_periph_pkg;

  // Bus and counter widths
  localparam int unsigned AddrWidth       = 64;
  localparam int unsigned DataWidth       = 64;
  localparam int unsigned StrbWidth       = DataWidth / 8;
  localparam int unsigned PerfCountWidth  = 32;
  localparam int unsigned CycleCountWidth = 64;
  localparam int unsigned HartIdWidth     = 10;

  // Only the low address bits take part in decoding
  localparam int unsigned PeriphAddrWidth = 16;

  // Register byte offsets inside the peripheral window
  typedef enum logic [PeriphAddrWidth-1:0] {
    TCDMStartAddressReg = 16'h0000,
    TCDMEndAddressReg   = 16'h0008,
    NrCoresReg          = 16'h0010,
    FetchEnableReg      = 16'h0018,
    ScratchReg          = 16'h0020,
    WakeUpReg           = 16'h0028,
    CycleCountReg       = 16'h0030,
    BarrierReg          = 16'h0038,
    ClusterIdReg        = 16'h0040,
    TcdmAccessedReg     = 16'h0048,
    TcdmCongestedReg    = 16'h0050
  } periph_addr_e;

  // Perf counter k lives at PerfCounterBase + 8*k
  localparam logic [PeriphAddrWidth-1:0] PerfCounterBase = 16'h1000;

  // Event strobes raised by one core
  typedef struct packed {
    logic retired_instr;
    logic retired_load;
    logic retired_i;
    logic retired_acc;
  } core_events_t;

  localparam int unsigned NumCoreEvents = $bits(core_events_t);

  // Event strobes raised by the TCDM interconnect
  typedef struct packed {
    logic inc_accessed;
    logic inc_congested;
  } tcdm_events_t;

  typedef logic [PerfCountWidth-1:0] perf_count_t;

  // Plain request, accepted in the cycle valid is high
  typedef struct packed {
    logic                 valid;
    logic                 write;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [StrbWidth-1:0] wstrb;
  } periph_req_t;

  // Response returned combinationally in the request cycle
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 error;
  } periph_rsp_t;

endpackage

`default_nettype wire

// ==== design/cluster_event_sampler.sv ====
// Event sampler that registers core and TCDM event strobes into a flat vector
`timescale 1ns/10ps
`default_nettype none

module cluster_event_sampler #(
  parameter int unsigned NrCores = 4
) (
  input  logic                                            clk_i,
  input  logic                                            rst_i,
  input  cluster_periph_pkg::core_events_t [NrCores-1:0]  core_events_i,
  input  cluster_periph_pkg::tcdm_events_t                tcdm_events_i,
  output logic [NrCores*cluster_periph_pkg::NumCoreEvents-1:0] sampled_events_o,
  output cluster_periph_pkg::tcdm_events_t                tcdm_sampled_o
);

  localparam int unsigned CoreEvW   = cluster_periph_pkg::NumCoreEvents;
  localparam int unsigned NumEvents = NrCores * CoreEvW;

  logic [NumEvents-1:0] flat_events;

  // Core c owns bits [c*CoreEvW +: CoreEvW] of the flat vector
  always_comb begin
    for (int unsigned c = 0; c < NrCores; c++) begin
      flat_events[c*CoreEvW +: CoreEvW] = core_events_i[c];
    end
  end

  // One register stage between the cores and the counter adders
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sampled_events_o <= '0;
      tcdm_sampled_o   <= '0;
    end else begin
      sampled_events_o <= flat_events;
      tcdm_sampled_o   <= tcdm_events_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/cluster_perf_counters.sv ====
// Counter bank with the cycle counter, per-event counters and TCDM counters
`timescale 1ns/10ps
`default_nettype none

module cluster_perf_counters #(
  parameter int unsigned NrCores = 4
) (
  input  logic                                                 clk_i,
  input  logic                                                 rst_i,
  input  logic [NrCores*cluster_periph_pkg::NumCoreEvents-1:0] sampled_events_i,
  input  cluster_periph_pkg::tcdm_events_t                     tcdm_sampled_i,
  output cluster_periph_pkg::perf_count_t
         [NrCores*cluster_periph_pkg::NumCoreEvents-1:0]       perf_counts_o,
  output logic [cluster_periph_pkg::CycleCountWidth-1:0]       cycle_count_o,
  output cluster_periph_pkg::perf_count_t                      tcdm_accessed_o,
  output cluster_periph_pkg::perf_count_t                      tcdm_congested_o
);

  localparam int unsigned NumPerfCount = NrCores * cluster_periph_pkg::NumCoreEvents;
  localparam int unsigned CycleW       = cluster_periph_pkg::CycleCountWidth;

  cluster_periph_pkg::perf_count_t [NumPerfCount-1:0] perf_count_q;
  cluster_periph_pkg::perf_count_t                    tcdm_accessed_q;
  cluster_periph_pkg::perf_count_t                    tcdm_congested_q;
  logic [CycleW-1:0]                                  cycle_count_q;

  // Free-running cycle counter, wraps at 64 bits
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      cycle_count_q <= '0;
    end else begin
      cycle_count_q <= cycle_count_q + CycleW'(1);
    end
  end

  // Every sampled event bit adds one to its own counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      perf_count_q <= '0;
    end else begin
      for (int unsigned i = 0; i < NumPerfCount; i++) begin
        perf_count_q[i] <= perf_count_q[i]
                         + cluster_periph_pkg::perf_count_t'(sampled_events_i[i]);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tcdm_accessed_q  <= '0;
      tcdm_congested_q <= '0;
    end else begin
      tcdm_accessed_q  <= tcdm_accessed_q
                        + cluster_periph_pkg::perf_count_t'(tcdm_sampled_i.inc_accessed);
      tcdm_congested_q <= tcdm_congested_q
                        + cluster_periph_pkg::perf_count_t'(tcdm_sampled_i.inc_congested);
    end
  end

  assign perf_counts_o    = perf_count_q;
  assign cycle_count_o    = cycle_count_q;
  assign tcdm_accessed_o  = tcdm_accessed_q;
  assign tcdm_congested_o = tcdm_congested_q;

  // Software measures time by differencing reads, so no step may be skipped
  cycle_count_step: assert property (
    @(posedge clk_i) disable iff (rst_i)
    $past(!rst_i) |-> cycle_count_q == $past(cycle_count_q) + CycleW'(1)
  );

endmodule

`default_nettype wire

// ==== design/cluster_periph_regs.sv ====
// Register decoder with fetch enable, scratch, wake-up and the read data mux
`timescale 1ns/10ps
`default_nettype none

module cluster_periph_regs #(
  parameter int unsigned NrCores          = 4,
  parameter logic [31:0] TCDMStartAddress = 32'h1000_0000,
  parameter logic [31:0] TCDMEndAddress   = 32'h1002_0000
) (
  input  logic                                              clk_i,
  input  logic                                              rst_i,
  input  cluster_periph_pkg::periph_req_t                   req_i,
  output cluster_periph_pkg::periph_rsp_t                   rsp_o,
  output logic [NrCores-1:0]                                wake_up_o,
  input  logic [cluster_periph_pkg::HartIdWidth-1:0]        cluster_hart_base_id_i,
  input  cluster_periph_pkg::perf_count_t
         [NrCores*cluster_periph_pkg::NumCoreEvents-1:0]    perf_counts_i,
  input  logic [cluster_periph_pkg::CycleCountWidth-1:0]    cycle_count_i,
  input  cluster_periph_pkg::perf_count_t                   tcdm_accessed_i,
  input  cluster_periph_pkg::perf_count_t                   tcdm_congested_i
);

  localparam int unsigned NumPerfCount = NrCores * cluster_periph_pkg::NumCoreEvents;
  localparam int unsigned PerfIdxWidth = $clog2(NumPerfCount);
  localparam int unsigned DataW        = cluster_periph_pkg::DataWidth;
  localparam int unsigned StrbW        = cluster_periph_pkg::StrbWidth;
  localparam int unsigned PAddrW       = cluster_periph_pkg::PeriphAddrWidth;

  logic [PAddrW-1:0]  addr;
  logic [PAddrW-1:0]  perf_offset;
  logic               perf_hit;
  logic [DataW-1:0]   wmask;
  logic [DataW-1:0]   fetch_merged;
  logic [NrCores-1:0] fetch_enable_q, fetch_enable_d;
  logic [NrCores-1:0] wake_up_q, wake_up_d;
  logic [DataW-1:0]   scratch_q, scratch_d;

  // Takes the bytes of src where mask is set and keeps dst elsewhere
  function automatic logic [DataW-1:0] merge_bytes(input logic [DataW-1:0] dst,
                                                   input logic [DataW-1:0] src,
                                                   input logic [DataW-1:0] mask);
    return (src & mask) | (dst & ~mask);
  endfunction

  // Upper address bits are ignored
  assign addr = req_i.addr[PAddrW-1:0];

  // Expand byte strobes into a bit mask
  always_comb begin
    for (int unsigned b = 0; b < StrbW; b++) begin
      wmask[b*8 +: 8] = {8{req_i.wstrb[b]}};
    end
  end

  // Perf counter window starts at PerfCounterBase, 8 bytes per counter
  assign perf_offset = addr - cluster_periph_pkg::PerfCounterBase;
  assign perf_hit    = (addr >= cluster_periph_pkg::PerfCounterBase) &&
                       (perf_offset < NumPerfCount * 8);

  always_comb begin
    rsp_o          = '0;
    fetch_enable_d = fetch_enable_q;
    scratch_d      = scratch_q;
    wake_up_d      = '0;
    fetch_merged   = merge_bytes(DataW'(fetch_enable_q), req_i.wdata, wmask);

    if (req_i.valid) begin
      if (req_i.write) begin
        case (cluster_periph_pkg::periph_addr_e'(addr))
          cluster_periph_pkg::FetchEnableReg: begin
            // Bits above NrCores have no core behind them
            fetch_enable_d = fetch_merged[NrCores-1:0];
          end
          cluster_periph_pkg::ScratchReg: begin
            scratch_d = merge_bytes(scratch_q, req_i.wdata, wmask);
          end
          cluster_periph_pkg::WakeUpReg: begin
            wake_up_d = req_i.wdata[NrCores-1:0] & wmask[NrCores-1:0];
          end
          default: begin
            // A write with no strobes touches nothing and is harmless
            rsp_o.error = |req_i.wstrb;
          end
        endcase
      end else begin
        case (cluster_periph_pkg::periph_addr_e'(addr))
          cluster_periph_pkg::TCDMStartAddressReg: begin
            rsp_o.rdata = DataW'(TCDMStartAddress);
          end
          cluster_periph_pkg::TCDMEndAddressReg: begin
            rsp_o.rdata = DataW'(TCDMEndAddress);
          end
          cluster_periph_pkg::NrCoresReg: begin
            rsp_o.rdata = DataW'(NrCores);
          end
          cluster_periph_pkg::FetchEnableReg: begin
            rsp_o.rdata = DataW'(fetch_enable_q);
          end
          cluster_periph_pkg::ScratchReg: begin
            rsp_o.rdata = scratch_q;
          end
          cluster_periph_pkg::WakeUpReg: begin
            // Wake-up is write only
            rsp_o.error = 1'b1;
          end
          cluster_periph_pkg::CycleCountReg: begin
            rsp_o.rdata = DataW'(cycle_count_i);
          end
          cluster_periph_pkg::BarrierReg: begin
            rsp_o.rdata = '0;
          end
          cluster_periph_pkg::ClusterIdReg: begin
            rsp_o.rdata = DataW'(cluster_hart_base_id_i);
          end
          cluster_periph_pkg::TcdmAccessedReg: begin
            rsp_o.rdata = DataW'(tcdm_accessed_i);
          end
          cluster_periph_pkg::TcdmCongestedReg: begin
            rsp_o.rdata = DataW'(tcdm_congested_i);
          end
          default: begin
            if (perf_hit) begin
              rsp_o.rdata = DataW'(perf_counts_i[perf_offset[3 +: PerfIdxWidth]]);
            end else begin
              rsp_o.error = 1'b1;
            end
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      fetch_enable_q <= '0;
      scratch_q      <= '0;
      wake_up_q      <= '0;
    end else begin
      fetch_enable_q <= fetch_enable_d;
      scratch_q      <= scratch_d;
      wake_up_q      <= wake_up_d;
    end
  end

  assign wake_up_o = wake_up_q;

  // An error is only ever the answer to a request
  error_needs_valid: assert property (
    @(posedge clk_i) disable iff (rst_i)
    rsp_o.error |-> req_i.valid
  );

  // The wake-up pulse lasts one cycle and only follows a wake-up write
  wake_up_single_pulse: assert property (
    @(posedge clk_i) disable iff (rst_i)
    !(req_i.valid && req_i.write && addr == cluster_periph_pkg::WakeUpReg)
    |=> wake_up_o == '0
  );

endmodule

`default_nettype wire

// ==== design/cluster_peripheral.sv ====
// Top level connecting the event sampler, the counter bank and the register decoder
`timescale 1ns/10ps
`default_nettype none

module cluster_peripheral #(
  parameter int unsigned NrCores          = 4,
  parameter logic [31:0] TCDMStartAddress = 32'h1000_0000,
  parameter logic [31:0] TCDMEndAddress   = 32'h1002_0000
) (
  input  logic                                           clk_i,
  input  logic                                           rst_i,
  input  cluster_periph_pkg::periph_req_t                req_i,
  output cluster_periph_pkg::periph_rsp_t                rsp_o,
  output logic [NrCores-1:0]                             wake_up_o,
  input  logic [cluster_periph_pkg::HartIdWidth-1:0]     cluster_hart_base_id_i,
  input  cluster_periph_pkg::core_events_t [NrCores-1:0] core_events_i,
  input  cluster_periph_pkg::tcdm_events_t               tcdm_events_i
);

  localparam int unsigned NumPerfCount = NrCores * cluster_periph_pkg::NumCoreEvents;

  logic [NumPerfCount-1:0]                            sampled_events;
  cluster_periph_pkg::tcdm_events_t                   tcdm_sampled;
  cluster_periph_pkg::perf_count_t [NumPerfCount-1:0] perf_counts;
  logic [cluster_periph_pkg::CycleCountWidth-1:0]     cycle_count;
  cluster_periph_pkg::perf_count_t                    tcdm_accessed;
  cluster_periph_pkg::perf_count_t                    tcdm_congested;

  cluster_event_sampler #(
    .NrCores (NrCores)
  ) i_sampler (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .core_events_i    (core_events_i),
    .tcdm_events_i    (tcdm_events_i),
    .sampled_events_o (sampled_events),
    .tcdm_sampled_o   (tcdm_sampled)
  );

  cluster_perf_counters #(
    .NrCores (NrCores)
  ) i_counters (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .sampled_events_i (sampled_events),
    .tcdm_sampled_i   (tcdm_sampled),
    .perf_counts_o    (perf_counts),
    .cycle_count_o    (cycle_count),
    .tcdm_accessed_o  (tcdm_accessed),
    .tcdm_congested_o (tcdm_congested)
  );

  cluster_periph_regs #(
    .NrCores          (NrCores),
    .TCDMStartAddress (TCDMStartAddress),
    .TCDMEndAddress   (TCDMEndAddress)
  ) i_regs (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .req_i                  (req_i),
    .rsp_o                  (rsp_o),
    .wake_up_o              (wake_up_o),
    .cluster_hart_base_id_i (cluster_hart_base_id_i),
    .perf_counts_i          (perf_counts),
    .cycle_count_i          (cycle_count),
    .tcdm_accessed_i        (tcdm_accessed),
    .tcdm_congested_i       (tcdm_congested)
  );

endmodule

`default_nettype wire

// ==== sim/tb_cluster_peripheral.sv ====
// Testbench for the cluster peripheral with LFSR stimulus, shadow model, reference and checks
`timescale 1ns/10ps
`default_nettype none

module tb_cluster_peripheral;

  localparam int unsigned NrCores      = 4;
  localparam int unsigned NumCounts    = NrCores * cluster_periph_pkg::NumCoreEvents;
  localparam logic [31:0] TcdmStart    = 32'h1000_0000;
  localparam logic [31:0] TcdmEnd      = 32'h1002_0000;
  localparam logic [9:0]  HartBaseId   = 10'h2a4;
  localparam int unsigned HalfPeriod   = 5;
  localparam int unsigned StartTimeout = 20;

  logic                                           clk_i;
  logic                                           rst_i;
  cluster_periph_pkg::periph_req_t                req_i;
  cluster_periph_pkg::periph_rsp_t                rsp_o;
  logic [NrCores-1:0]                             wake_up_o;
  logic [cluster_periph_pkg::HartIdWidth-1:0]     cluster_hart_base_id_i;
  cluster_periph_pkg::core_events_t [NrCores-1:0] core_events_i;
  cluster_periph_pkg::tcdm_events_t               tcdm_events_i;

  // Shadow model of every register software can observe
  logic [NrCores-1:0]              fetch_enable_ref;
  logic [63:0]                     scratch_ref;
  logic [63:0]                     cycle_ref;
  cluster_periph_pkg::perf_count_t perf_ref [NumCounts];
  cluster_periph_pkg::perf_count_t accessed_ref;
  cluster_periph_pkg::perf_count_t congested_ref;

  // Expectations handed from the driving process to the comparing process
  cluster_periph_pkg::periph_rsp_t exp_rsp;
  cluster_periph_pkg::periph_rsp_t last_rsp;
  logic [NrCores-1:0]              exp_wake;
  logic [NrCores-1:0]              wake_next;
  logic                            check_en;
  logic                            rsp_check_en;
  string                           test_name;

  logic [31:0] lfsr_q;
  int unsigned rsp_errors;
  int unsigned wake_errors;
  int unsigned timeout_errors;

  cluster_peripheral #(
    .NrCores          (NrCores),
    .TCDMStartAddress (TcdmStart),
    .TCDMEndAddress   (TcdmEnd)
  ) uut (
    .clk_i                  (clk_i),
    .rst_i                  (rst_i),
    .req_i                  (req_i),
    .rsp_o                  (rsp_o),
    .wake_up_o              (wake_up_o),
    .cluster_hart_base_id_i (cluster_hart_base_id_i),
    .core_events_i          (core_events_i),
    .tcdm_events_i          (tcdm_events_i)
  );

  always #HalfPeriod clk_i = ~clk_i;

  // Fibonacci LFSR with taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic take_bit();
    lfsr_q = lfsr_next(lfsr_q);
    return lfsr_q[0];
  endfunction

  // Collects n fresh bits, lowest bit first
  function automatic logic [63:0] take_bits(input int unsigned n);
    logic [63:0] bits;
    bits = '0;
    for (int unsigned i = 0; i < n; i++) begin
      bits[i] = take_bit();
    end
    return bits;
  endfunction

  function automatic logic [63:0] strobe_mask(input logic [7:0] strb);
    logic [63:0] mask;
    for (int b = 0; b < 8; b++) begin
      mask[b*8 +: 8] = strb[b] ? 8'hff : 8'h00;
    end
    return mask;
  endfunction

  // Expected response for a request, taken from the shadow model before the request lands
  function automatic cluster_periph_pkg::periph_rsp_t ref_rsp(
      input cluster_periph_pkg::periph_req_t req);
    cluster_periph_pkg::periph_rsp_t rsp;
    logic [15:0]                     a;
    int                              idx;
    rsp = '0;
    a   = req.addr[15:0];
    if (req.valid && req.write) begin
      if (a != cluster_periph_pkg::FetchEnableReg && a != cluster_periph_pkg::ScratchReg &&
          a != cluster_periph_pkg::WakeUpReg) begin
        rsp.error = |req.wstrb;
      end
    end else if (req.valid) begin
      case (a)
        cluster_periph_pkg::TCDMStartAddressReg: rsp.rdata = 64'(TcdmStart);
        cluster_periph_pkg::TCDMEndAddressReg:   rsp.rdata = 64'(TcdmEnd);
        cluster_periph_pkg::NrCoresReg:          rsp.rdata = 64'(NrCores);
        cluster_periph_pkg::FetchEnableReg:      rsp.rdata = 64'(fetch_enable_ref);
        cluster_periph_pkg::ScratchReg:          rsp.rdata = scratch_ref;
        cluster_periph_pkg::WakeUpReg:           rsp.error = 1'b1;
        cluster_periph_pkg::CycleCountReg:       rsp.rdata = cycle_ref;
        cluster_periph_pkg::BarrierReg:          rsp.rdata = '0;
        cluster_periph_pkg::ClusterIdReg:        rsp.rdata = 64'(HartBaseId);
        cluster_periph_pkg::TcdmAccessedReg:     rsp.rdata = 64'(accessed_ref);
        cluster_periph_pkg::TcdmCongestedReg:    rsp.rdata = 64'(congested_ref);
        default: begin
          if (a >= cluster_periph_pkg::PerfCounterBase &&
              a < cluster_periph_pkg::PerfCounterBase + 16'(NumCounts * 8)) begin
            idx       = int'(a - cluster_periph_pkg::PerfCounterBase) / 8;
            rsp.rdata = 64'(perf_ref[idx]);
          end else begin
            rsp.error = 1'b1;
          end
        end
      endcase
    end
    return rsp;
  endfunction

  // Writes change the shadow from the next cycle on, wake-up only for one cycle
  task automatic apply_write(input cluster_periph_pkg::periph_req_t req);
    logic [63:0] mask;
    mask      = strobe_mask(req.wstrb);
    wake_next = '0;
    if (req.valid && req.write) begin
      case (req.addr[15:0])
        cluster_periph_pkg::FetchEnableReg: begin
          fetch_enable_ref = NrCores'((req.wdata & mask) | (64'(fetch_enable_ref) & ~mask));
        end
        cluster_periph_pkg::ScratchReg: scratch_ref = (req.wdata & mask) | (scratch_ref & ~mask);
        cluster_periph_pkg::WakeUpReg:  wake_next = NrCores'(req.wdata & mask);
        default: begin
        end
      endcase
    end
  endtask

  task automatic check_rsp(input string name, input cluster_periph_pkg::periph_rsp_t exp,
                           input cluster_periph_pkg::periph_rsp_t act);
    if (act !== exp) begin
      rsp_errors++;
      $display("mismatch %s: expected rdata=%h error=%b, actual rdata=%h error=%b",
               name, exp.rdata, exp.error, act.rdata, act.error);
    end
  endtask

  task automatic check_wake(input string name, input logic [NrCores-1:0] exp,
                            input logic [NrCores-1:0] act);
    if (act !== exp) begin
      wake_errors++;
      $display("mismatch %s: expected wake_up=%b, actual wake_up=%b", name, exp, act);
    end
  endtask

  // Compares one time unit before each rising edge, when all outputs have settled
  always @(negedge clk_i) begin
    #(HalfPeriod - 1);
    if (check_en) begin
      if (rsp_check_en) begin
        check_rsp(test_name, exp_rsp, rsp_o);
      end
      check_wake(test_name, exp_wake, wake_up_o);
    end
  end

  task automatic drive_cycle(input string name, input cluster_periph_pkg::periph_req_t req,
                             input logic check);
    @(negedge clk_i);
    req_i        = req;
    test_name    = name;
    exp_rsp      = ref_rsp(req);
    rsp_check_en = check;
    exp_wake     = wake_next;
    apply_write(req);
  endtask

  // Random upper address bits must not change the decode
  task automatic access(input string name, input logic wr, input logic [15:0] offset,
                        input logic [63:0] wdata, input logic [7:0] wstrb, input logic check);
    cluster_periph_pkg::periph_req_t req;
    req.valid       = 1'b1;
    req.write       = wr;
    req.addr        = take_bits(64);
    req.addr[15:0]  = offset;
    req.wdata       = wdata;
    req.wstrb       = wstrb;
    drive_cycle(name, req, check);
    #(HalfPeriod - 1);
    last_rsp = rsp_o;
  endtask

  task automatic idle(input int unsigned n);
    for (int unsigned i = 0; i < n; i++) begin
      drive_cycle("idle", '0, 1'b1);
    end
  endtask

  // Counter index of an event is its core times four plus its bit in core_events_t
  task automatic drive_events(input int unsigned n);
    cluster_periph_pkg::core_events_t ev;
    for (int unsigned i = 0; i < n; i++) begin
      drive_cycle("events", '0, 1'b1);
      for (int unsigned c = 0; c < NrCores; c++) begin
        ev.retired_instr = take_bit();
        ev.retired_load  = take_bit();
        ev.retired_i     = take_bit();
        ev.retired_acc   = take_bit();
        core_events_i[c] = ev;
        perf_ref[c*4 + 3] = perf_ref[c*4 + 3] + 32'(ev.retired_instr);
        perf_ref[c*4 + 2] = perf_ref[c*4 + 2] + 32'(ev.retired_load);
        perf_ref[c*4 + 1] = perf_ref[c*4 + 1] + 32'(ev.retired_i);
        perf_ref[c*4]     = perf_ref[c*4] + 32'(ev.retired_acc);
      end
      tcdm_events_i.inc_accessed  = take_bit();
      tcdm_events_i.inc_congested = take_bit();
      accessed_ref  = accessed_ref + 32'(tcdm_events_i.inc_accessed);
      congested_ref = congested_ref + 32'(tcdm_events_i.inc_congested);
    end
    drive_cycle("events_off", '0, 1'b1);
    core_events_i = '0;
    tcdm_events_i = '0;
  endtask

  task automatic wait_counter_start(output logic started);
    int unsigned polls;
    started = 1'b0;
    polls   = 0;
    while (!started && polls < StartTimeout) begin
      access("start_poll", 1'b0, cluster_periph_pkg::CycleCountReg, '0, '0, 1'b0);
      started = last_rsp.rdata != '0;
      polls++;
    end
    if (!started) begin
      timeout_errors++;
      $display("timeout: the cycle counter did not start within %0d cycles", StartTimeout);
    end
  endtask

  initial begin
    logic        started;
    logic [63:0] first;
    logic [15:0] off;
    clk_i                  = 1'b0;
    rst_i                  = 1'b1;
    req_i                  = '0;
    cluster_hart_base_id_i = HartBaseId;
    core_events_i          = '0;
    tcdm_events_i          = '0;
    lfsr_q                 = 32'hebadec91;
    fetch_enable_ref       = '0;
    scratch_ref            = '0;
    cycle_ref              = '0;
    accessed_ref           = '0;
    congested_ref          = '0;
    foreach (perf_ref[k]) perf_ref[k] = '0;
    exp_rsp        = '0;
    exp_wake       = '0;
    wake_next      = '0;
    check_en       = 1'b0;
    rsp_check_en   = 1'b0;
    test_name      = "reset";
    rsp_errors     = 0;
    wake_errors    = 0;
    timeout_errors = 0;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_i    = 1'b0;
    check_en = 1'b1;

    wait_counter_start(started);
    if (started) begin
      access("tcdm_start", 1'b0, cluster_periph_pkg::TCDMStartAddressReg, '0, '0, 1'b1);
      access("tcdm_end", 1'b0, cluster_periph_pkg::TCDMEndAddressReg, '0, '0, 1'b1);
      access("nr_cores", 1'b0, cluster_periph_pkg::NrCoresReg, '0, '0, 1'b1);
      access("cluster_id", 1'b0, cluster_periph_pkg::ClusterIdReg, '0, '0, 1'b1);
      access("barrier", 1'b0, cluster_periph_pkg::BarrierReg, '0, '0, 1'b1);

      for (int i = 0; i < 24; i++) begin
        off = (i % 2 == 1) ? cluster_periph_pkg::FetchEnableReg : cluster_periph_pkg::ScratchReg;
        access("merge_write", 1'b1, off, take_bits(64), 8'(take_bits(8)), 1'b1);
        access("merge_read", 1'b0, off, '0, '0, 1'b1);
      end

      for (int i = 0; i < 6; i++) begin
        access("wake_write", 1'b1, cluster_periph_pkg::WakeUpReg, take_bits(64),
               8'(take_bits(8)) | 8'(i % 2), 1'b1);
        idle(2);
      end
      access("wake_back_to_back", 1'b1, cluster_periph_pkg::WakeUpReg, 64'hf, 8'h01, 1'b1);
      access("wake_back_to_back", 1'b1, cluster_periph_pkg::WakeUpReg, 64'h5, 8'h01, 1'b1);
      idle(2);

      drive_events(200);
      idle(2);
      for (int k = 0; k < NumCounts; k++) begin
        access("perf_count", 1'b0, cluster_periph_pkg::PerfCounterBase + 16'(k * 8),
               '0, '0, 1'b1);
      end
      access("tcdm_accessed", 1'b0, cluster_periph_pkg::TcdmAccessedReg, '0, '0, 1'b1);
      access("tcdm_congested", 1'b0, cluster_periph_pkg::TcdmCongestedReg, '0, '0, 1'b1);

      // Second read lands 37 rising edges after the first
      access("cycle_first", 1'b0, cluster_periph_pkg::CycleCountReg, '0, '0, 1'b0);
      first = last_rsp.rdata;
      idle(36);
      cycle_ref = first + 64'd37;
      access("cycle_second", 1'b0, cluster_periph_pkg::CycleCountReg, '0, '0, 1'b1);

      access("unmapped_read", 1'b0, 16'h0058, '0, '0, 1'b1);
      access("unmapped_read", 1'b0, 16'h0ff8, '0, '0, 1'b1);
      access("perf_out_of_range", 1'b0,
             cluster_periph_pkg::PerfCounterBase + 16'(NumCounts * 8), '0, '0, 1'b1);
      access("wake_read", 1'b0, cluster_periph_pkg::WakeUpReg, '0, '0, 1'b1);
      access("ro_write", 1'b1, cluster_periph_pkg::NrCoresReg, take_bits(64), 8'h01, 1'b1);
      access("ro_write", 1'b1, cluster_periph_pkg::CycleCountReg, take_bits(64), 8'h80, 1'b1);
      access("ro_write_no_strobe", 1'b1, cluster_periph_pkg::NrCoresReg, take_bits(64),
             8'h00, 1'b1);
      idle(2);
    end

    @(posedge clk_i);
    $display("errors: rsp=%0d wake=%0d timeout=%0d", rsp_errors, wake_errors, timeout_errors);
    if (rsp_errors + wake_errors + timeout_errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== cluster_peripheral.f ====
design/cluster_periph_pkg.sv
design/cluster_event_sampler.sv
design/cluster_perf_counters.sv
design/cluster_periph_regs.sv
design/cluster_peripheral.sv
sim/tb_cluster_peripheral.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_cluster_peripheral
SRCS := $(shell cat cluster_peripheral.f)

.PHONY: all run clean

all: run

$(BIN): cluster_peripheral.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f cluster_peripheral.f \
	  --top-module tb_cluster_peripheral -Mdir obj_dir -o Vtb_cluster_peripheral

run: $(BIN)
	./$(BIN) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
